//--- testbench/fetch_patterns.txt
# load <addr hex> <data hex> <wstrb hex> <expected bresp hex, 0 okay, 2 slverr>
# fetch <packet count decimal>, redirect <target pc hex>
load 80000000 00100093 f 0
load 80000004 00200113 f 0
load 80000008 00300193 f 0
load 8000000c 00400213 f 0
load 80000010 00500293 f 0
load 80000014 00600313 f 0
load 80000018 00700393 f 0
load 8000001c 00800413 f 0
load 80000020 00900493 f 0
load 80000024 00a00513 f 0
load 80000028 00b00593 f 0
load 8000002c 00c00613 f 0
load 80000008 0000ffff 3 0
load 80000014 ab000000 8 0
load 00000010 deadbeef f 2
load 80000400 deadbeef f 2
redirect 80000000
fetch 10
redirect 80000008
fetch 4
redirect 00001000
fetch 2
load 80000030 00d00693 f 0
load 80000034 00e00713 f 0
load 80000038 00f00793 f 0
load 8000003c 01000813 f 0
load 8000000c 5a000000 c 0
load 800003f8 0000006f f 0
load 800003fc 00000013 f 0
redirect 80000000
fetch 16
redirect 800003f8
fetch 3
redirect 80000004
fetch 5

//--- src.f
common/axi_pkg.sv
common/core_pkg.sv
isram/isram.sv
ifu/ifu.sv
src/fetch_top.sv
testbench/tb_fetch_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch subsystem testbench with verilator
set -e

cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing \
    -f src.f \
    --top-module tb_fetch_top \
    --Mdir obj_dir \
    -o sim_fetch_top

./obj_dir/sim_fetch_top 2>&1 | tee "$log" || true

if grep -q "SIMULATION FAILED" "$log"; then
    echo "fetch_top: test failed, see $log"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log"; then
    echo "fetch_top: run ended without a result, see $log"
    exit 1
fi
echo "fetch_top: test ok"

//--- testbench/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    import axi_pkg::*;
    import core_pkg::*;

    // cycles any single wait may take
    localparam int timeout_cycles = 200;

    logic       clk;
    logic       rst_n;
    axi_aw_t    aw;
    logic       awready;
    axi_w_t     w;
    logic       wready;
    axi_b_t     b;
    logic       bready;
    redirect_t  redirect;
    logic       redirect_ready;
    fetch_pkt_t fetch;
    logic       fetch_valid;
    logic       fetch_ready;

    // reference copy of the instruction memory
    logic [axi_data_w-1:0] ref_mem [isram_words];
    // pc of the next packet decode should see
    logic [pc_w-1:0]       exp_pc;

    fetch_top i_fetch_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .aw             (aw),
        .awready        (awready),
        .w              (w),
        .wready         (wready),
        .b              (b),
        .bready         (bready),
        .redirect       (redirect),
        .redirect_ready (redirect_ready),
        .fetch          (fetch),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // report what went wrong and end the run
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_fetch(input fetch_pkt_t act, input fetch_pkt_t exp);
        if (act !== exp) begin
            stop_run($sformatf(
                "[ERROR] %0d ns fetch expected pc=%h instr=%h fault=%b got pc=%h instr=%h fault=%b",
                $time, exp.pc, exp.instr, exp.fault, act.pc, act.instr, act.fault));
        end
    endtask

    task automatic check_bresp(input axi_resp_t act, input axi_resp_t exp);
        if (act !== exp) begin
            stop_run($sformatf("[ERROR] %0d ns b.bresp expected %h got %h", $time, exp, act));
        end
    endtask

    // packet decode should get for a pc according to the model
    function automatic fetch_pkt_t expected_packet(input logic [pc_w-1:0] pc);
        fetch_pkt_t      pkt;
        logic [pc_w-1:0] offset;
        offset = pc - isram_base;
        pkt.pc = pc;
        if (offset < pc_w'(isram_words * 4)) begin
            pkt.instr = ref_mem[offset[isram_idx_w+1:2]];
            pkt.fault = 1'b0;
        end else begin
            // bus error turns into a nop with fault
            pkt.instr = inst_nop;
            pkt.fault = 1'b1;
        end
        return pkt;
    endfunction

    // merge an accepted load into the model
    task automatic apply_load(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [pc_w-1:0] offset;
        offset = addr - isram_base;
        for (int i = 0; i < axi_strb_w; i++) begin
            if (strb[i]) begin
                ref_mem[offset[isram_idx_w+1:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    // all valids and readies low
    task automatic quiet_inputs();
        aw.awvalid     = 1'b0;
        w.wvalid       = 1'b0;
        bready         = 1'b0;
        redirect.valid = 1'b0;
        fetch_ready    = 1'b0;
    endtask

    // one write over the load port
    task automatic load_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input axi_resp_t exp_resp);
        int waited;
        @(negedge clk);
        quiet_inputs();
        aw.awaddr  = addr;
        aw.awvalid = 1'b1;
        w.wdata    = data;
        w.wstrb    = strb;
        w.wvalid   = 1'b1;
        waited     = 0;
        @(posedge clk);
        while (!(awready && wready)) begin
            waited++;
            if (waited > timeout_cycles) stop_run("timeout: load address/data not accepted");
            @(posedge clk);
        end
        @(negedge clk);
        aw.awvalid = 1'b0;
        w.wvalid   = 1'b0;
        // stall the response at random
        bready     = ($urandom % 2) == 0;
        waited     = 0;
        @(posedge clk);
        while (!(b.bvalid && bready)) begin
            waited++;
            if (waited > timeout_cycles) stop_run("timeout: no write response");
            @(negedge clk);
            bready = ($urandom % 2) == 0;
            @(posedge clk);
        end
        check_bresp(b.bresp, exp_resp);
        if (exp_resp == resp_okay) apply_load(addr, data, strb);
    endtask

    task automatic send_redirect(input logic [pc_w-1:0] target);
        int waited;
        int gap;
        // random gap lets the redirect hit a read in flight
        gap = $urandom % 4;
        repeat (gap) begin
            @(negedge clk);
            quiet_inputs();
        end
        @(negedge clk);
        quiet_inputs();
        redirect.target = target;
        redirect.valid  = 1'b1;
        waited          = 0;
        @(posedge clk);
        while (!redirect_ready) begin
            waited++;
            if (waited > timeout_cycles) stop_run("timeout: redirect never accepted");
            @(posedge clk);
        end
        // valid drops with the next command
        exp_pc = target;
    endtask

    // take count packets and check each one
    task automatic collect_packets(input int count);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < count) begin
            @(negedge clk);
            quiet_inputs();
            // random back-pressure from decode
            fetch_ready = ($urandom % 4) != 0;
            @(posedge clk);
            if (fetch_valid && fetch_ready) begin
                check_fetch(fetch, expected_packet(exp_pc));
                exp_pc = exp_pc + 32'd4;
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > timeout_cycles) stop_run("timeout: no fetch packet delivered");
            end
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          commands;
        int          count;
        string       line;
        string       cmd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        axi_resp_t   resp;
        void'($urandom(78465));
        rst_n       = 1'b0;
        aw          = '0;
        w           = '0;
        bready      = 1'b0;
        redirect    = '0;
        fetch_ready = 1'b0;
        exp_pc      = reset_pc;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("testbench/fetch_patterns.txt", "r");
        if (fd == 0) stop_run("cannot open testbench/fetch_patterns.txt");
        commands = 0;
        // one command per line
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // skip blank and comment lines
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            code = $sscanf(line, "%s", cmd);
            if (cmd == "load") begin
                code = $sscanf(line, "%s %h %h %h %h", cmd, addr, data, strb, resp);
                if (code != 5) stop_run({"bad load line in pattern file: ", line});
                load_word(addr, data, strb, resp);
            end else if (cmd == "fetch") begin
                code = $sscanf(line, "%s %d", cmd, count);
                if (code != 2) stop_run({"bad fetch line in pattern file: ", line});
                collect_packets(count);
            end else if (cmd == "redirect") begin
                code = $sscanf(line, "%s %h", cmd, addr);
                if (code != 2) stop_run({"bad redirect line in pattern file: ", line});
                send_redirect(addr);
            end else begin
                stop_run({"unknown command in pattern file: ", line});
            end
            commands++;
        end
        $fclose(fd);
        @(negedge clk);
        quiet_inputs();
        if (commands == 0) begin
            stop_run("pattern file held no commands");
        end else begin
            repeat (4) @(posedge clk);
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // program load port
    input  axi_pkg::axi_aw_t     aw,
    output logic                 awready,
    input  axi_pkg::axi_w_t      w,
    output logic                 wready,
    output axi_pkg::axi_b_t      b,
    input  logic                 bready,
    // redirect from decode
    input  core_pkg::redirect_t  redirect,
    output logic                 redirect_ready,
    // packets to decode
    output core_pkg::fetch_pkt_t fetch,
    output logic                 fetch_valid,
    input  logic                 fetch_ready
);

    import axi_pkg::*;

    // ifu to isram read link
    axi_ar_t ar;
    logic    arready;
    axi_r_t  r;
    logic    rready;

    ifu i_ifu (
        .clk            (clk),
        .rst_n          (rst_n),
        .ar             (ar),
        .arready        (arready),
        .r              (r),
        .rready         (rready),
        .redirect       (redirect),
        .redirect_ready (redirect_ready),
        .fetch          (fetch),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready)
    );

    // write side goes straight out as the load port
    isram i_isram (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready)
    );

endmodule

//--- ifu/ifu.sv
`timescale 1ns/1ps

module ifu (
    input  logic                 clk,
    input  logic                 rst_n,
    // read master toward the instruction sram
    output axi_pkg::axi_ar_t     ar,
    input  logic                 arready,
    input  axi_pkg::axi_r_t      r,
    output logic                 rready,
    // pc change from decode
    input  core_pkg::redirect_t  redirect,
    output logic                 redirect_ready,
    // instruction packet toward decode
    output core_pkg::fetch_pkt_t fetch,
    output logic                 fetch_valid,
    input  logic                 fetch_ready
);

    import axi_pkg::*;
    import core_pkg::*;

    typedef enum logic [1:0] {
        st_issue,
        st_wait,
        st_present,
        st_drain
    } state_t;

    state_t                state_q;
    state_t                state_d;
    // architectural pc, follows redirects at once
    logic [pc_w-1:0]       pc_q;
    logic [pc_w-1:0]       pc_d;
    // request still on ar belongs to a dead path
    logic                  stale_q;
    logic                  stale_d;
    logic                  rdy_q;
    logic                  arvalid_q;
    logic                  arvalid_d;
    logic [axi_addr_w-1:0] araddr_q;
    logic [axi_addr_w-1:0] araddr_d;
    logic                  redirect_hit;
    logic                  rsp_err;
    logic                  pkt_load;
    fetch_pkt_t            pkt_q;

    assign redirect_hit = redirect.valid && rdy_q;
    assign rsp_err      = (r.rresp != resp_okay);

    assign ar.araddr      = araddr_q;
    assign ar.arvalid     = arvalid_q;
    assign rready         = (state_q == st_wait) || (state_q == st_drain);
    assign redirect_ready = rdy_q;
    assign fetch          = pkt_q;
    assign fetch_valid    = (state_q == st_present);

    always_comb begin
        state_d   = state_q;
        pc_d      = pc_q;
        stale_d   = stale_q;
        arvalid_d = arvalid_q;
        araddr_d  = araddr_q;
        pkt_load  = 1'b0;
        // redirect always lands in the pc
        if (redirect_hit) begin
            pc_d = redirect.target;
        end
        case (state_q)
            st_issue: begin
                if (!arvalid_q) begin
                    // first request after reset
                    arvalid_d = 1'b1;
                    araddr_d  = pc_d;
                end else if (arready) begin
                    arvalid_d = 1'b0;
                    stale_d   = 1'b0;
                    state_d   = (stale_q || redirect_hit) ? st_drain : st_wait;
                end else if (redirect_hit) begin
                    // araddr must hold, so remember to drop the reply
                    stale_d = 1'b1;
                end
            end
            st_wait: begin
                if (r.rvalid && redirect_hit) begin
                    // reply dropped, go straight to the target
                    state_d   = st_issue;
                    arvalid_d = 1'b1;
                    araddr_d  = pc_d;
                end else if (r.rvalid) begin
                    pkt_load = 1'b1;
                    state_d  = st_present;
                end else if (redirect_hit) begin
                    state_d = st_drain;
                end
            end
            st_drain: begin
                // swallow the old reply, then fetch from pc
                if (r.rvalid) begin
                    state_d   = st_issue;
                    arvalid_d = 1'b1;
                    araddr_d  = pc_d;
                end
            end
            st_present: begin
                // redirect drops an untaken packet, and wins over accept
                if (redirect_hit || fetch_ready) begin
                    if (!redirect_hit) begin
                        pc_d = pc_q + pc_w'(4);
                    end
                    state_d   = st_issue;
                    arvalid_d = 1'b1;
                    araddr_d  = pc_d;
                end
            end
            default: begin
                state_d = st_issue;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= st_issue;
            pc_q      <= reset_pc;
            stale_q   <= 1'b0;
            arvalid_q <= 1'b0;
            rdy_q     <= 1'b0;
        end else begin
            state_q   <= state_d;
            pc_q      <= pc_d;
            stale_q   <= stale_d;
            arvalid_q <= arvalid_d;
            // decode may redirect any cycle
            rdy_q     <= 1'b1;
        end
    end

    // request address and packet payload
    always_ff @(posedge clk) begin
        araddr_q <= araddr_d;
        if (pkt_load) begin
            pkt_q.pc    <= araddr_q;
            pkt_q.instr <= rsp_err ? inst_nop : r.rdata;
            pkt_q.fault <= rsp_err;
        end
    end

endmodule

//--- isram/isram.sv
`timescale 1ns/1ps

module isram (
    input  logic             clk,
    input  logic             rst_n,
    // instruction read port from the fetch unit
    input  axi_pkg::axi_ar_t ar,
    output logic             arready,
    output axi_pkg::axi_r_t  r,
    input  logic             rready,
    // program load port
    input  axi_pkg::axi_aw_t aw,
    output logic             awready,
    input  axi_pkg::axi_w_t  w,
    output logic             wready,
    output axi_pkg::axi_b_t  b,
    input  logic             bready
);

    import axi_pkg::*;
    import core_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read_wait,
        st_read_resp,
        st_write_resp
    } state_t;

    // word storage, filled over the load port
    logic [axi_data_w-1:0]  mem [isram_words];

    state_t                 state_q;
    state_t                 state_d;
    // free running, picks the read delay
    logic [2:0]             lfsr_q;
    logic [1:0]             delay_q;
    logic [axi_addr_w-1:0]  raddr_q;
    logic [axi_data_w-1:0]  rdata_q;
    axi_resp_t              rresp_q;
    axi_resp_t              bresp_q;

    logic                   wr_fire;
    logic                   ar_fire;
    logic                   rd_fire;
    logic                   wr_in_range;
    logic                   rd_in_range;
    logic [isram_idx_w-1:0] widx;
    logic [isram_idx_w-1:0] ridx;

    // true when addr falls in the sram window
    function automatic logic in_range(input logic [axi_addr_w-1:0] addr);
        logic [axi_addr_w-1:0] offset;
        // below base wraps to a large offset
        offset = addr - isram_base;
        return offset < isram_bytes;
    endfunction

    // word index inside the window
    function automatic logic [isram_idx_w-1:0] word_idx(input logic [axi_addr_w-1:0] addr);
        logic [axi_addr_w-1:0] offset;
        offset = addr - isram_base;
        return offset[isram_idx_w+1:2];
    endfunction

    // write needs both aw and w, and wins over a read when idle
    assign wr_fire = (state_q == st_idle) && aw.awvalid && w.wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = (state_q == st_idle) && !(aw.awvalid && w.wvalid);
    assign ar_fire = ar.arvalid && arready;

    // delay elapsed, sample the array
    assign rd_fire = (state_q == st_read_wait) && (delay_q == 2'd0);

    assign wr_in_range = in_range(aw.awaddr);
    assign rd_in_range = in_range(raddr_q);
    assign widx        = word_idx(aw.awaddr);
    assign ridx        = word_idx(raddr_q);

    // response channels
    assign r.rdata  = rdata_q;
    assign r.rresp  = rresp_q;
    assign r.rvalid = (state_q == st_read_resp);
    assign b.bresp  = bresp_q;
    assign b.bvalid = (state_q == st_write_resp);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (wr_fire) begin
                    state_d = st_write_resp;
                end else if (ar_fire) begin
                    state_d = st_read_wait;
                end
            end
            st_read_wait: begin
                if (rd_fire) begin
                    state_d = st_read_resp;
                end
            end
            st_read_resp: begin
                // hold data until the master takes it
                if (rready) begin
                    state_d = st_idle;
                end
            end
            st_write_resp: begin
                if (bready) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            lfsr_q  <= 3'b001;
            delay_q <= 2'd0;
        end else begin
            state_q <= state_d;
            // x^3 + x^2 + 1, period 7
            lfsr_q  <= {lfsr_q[1:0], lfsr_q[2] ^ lfsr_q[1]};
            if (ar_fire) begin
                // 0..3 here gives 1..4 wait cycles
                delay_q <= lfsr_q[1:0];
            end else if ((state_q == st_read_wait) && (delay_q != 2'd0)) begin
                delay_q <= delay_q - 2'd1;
            end
        end
    end

    // array and payload registers
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            raddr_q <= ar.araddr;
        end
        if (rd_fire) begin
            rdata_q <= rd_in_range ? mem[ridx] : inst_nop;
            rresp_q <= rd_in_range ? resp_okay : resp_slverr;
        end
        if (wr_fire) begin
            bresp_q <= wr_in_range ? resp_okay : resp_slverr;
        end
        // out of range writes are dropped
        if (wr_fire && wr_in_range) begin
            for (int i = 0; i < axi_strb_w; i++) begin
                if (w.wstrb[i]) begin
                    mem[widx][8*i +: 8] <= w.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- common/core_pkg.sv
package core_pkg;

    // program counter and instruction widths
    localparam int pc_w   = 32;
    localparam int inst_w = 32;

    // first fetch address out of reset
    localparam logic [pc_w-1:0] reset_pc = 32'h8000_0000;

    // addi x0, x0, 0
    localparam logic [inst_w-1:0] inst_nop = 32'h0000_0013;

    // instruction sram window
    localparam logic [pc_w-1:0] isram_base  = 32'h8000_0000;
    localparam int              isram_words = 256;
    localparam int              isram_idx_w = $clog2(isram_words);
    localparam logic [pc_w-1:0] isram_bytes = pc_w'(isram_words * 4);

    // instruction handed to decode, tagged with its pc
    typedef struct packed {
        logic [pc_w-1:0]   pc;
        logic [inst_w-1:0] instr;
        // bus error on the read, instr is then a nop
        logic              fault;
    } fetch_pkt_t;

    // pc change requested by decode
    typedef struct packed {
        logic [pc_w-1:0] target;
        logic            valid;
    } redirect_t;

endpackage

//--- common/axi_pkg.sv
package axi_pkg;

    // bus widths for the axi-lite links
    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    // one strobe bit per data byte
    localparam int axi_strb_w = axi_data_w / 8;

    // response code as carried on rresp and bresp
    typedef logic [1:0] axi_resp_t;

    // only okay and slverr are produced here
    localparam axi_resp_t resp_okay   = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    // read address channel, master to slave
    typedef struct packed {
        logic [axi_addr_w-1:0] araddr;
        logic                  arvalid;
    } axi_ar_t;

    // read data channel, slave to master
    typedef struct packed {
        logic [axi_data_w-1:0] rdata;
        axi_resp_t             rresp;
        logic                  rvalid;
    } axi_r_t;

    // write address channel, master to slave
    typedef struct packed {
        logic [axi_addr_w-1:0] awaddr;
        logic                  awvalid;
    } axi_aw_t;

    // write data channel with byte strobes
    typedef struct packed {
        logic [axi_data_w-1:0] wdata;
        logic [axi_strb_w-1:0] wstrb;
        logic                  wvalid;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        axi_resp_t bresp;
        logic      bvalid;
    } axi_b_t;

    // ready bits run the other way as plain logic

endpackage
